/* hw/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] wordT;  // Data word, instruction and address
    typedef logic [4:0]  regAddrT;
    typedef logic [15:0] immT;
    typedef logic [4:0]  shamtT;
    typedef logic [3:0]  aluOpT;
    typedef logic [2:0]  branchT;

    localparam aluOpT aluAdd  = 4'd0;
    localparam aluOpT aluSub  = 4'd1;
    localparam aluOpT aluAnd  = 4'd2;
    localparam aluOpT aluOr   = 4'd3;
    localparam aluOpT aluXor  = 4'd4;
    localparam aluOpT aluSlt  = 4'd5;
    localparam aluOpT aluSltu = 4'd6;
    localparam aluOpT aluSll  = 4'd7;
    localparam aluOpT aluSrl  = 4'd8;
    localparam aluOpT aluSra  = 4'd9;
    localparam aluOpT aluLui  = 4'd10;

    localparam branchT brNone = 3'd0;
    localparam branchT brEq   = 3'd1;
    localparam branchT brNe   = 3'd2;
    localparam branchT brLez  = 3'd3;
    localparam branchT brGtz  = 3'd4;
    localparam branchT brLtz  = 3'd5;
    localparam branchT brGez  = 3'd6;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm  = 6'b000001;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;

    // Funct codes under opSpecial
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnSra  = 6'b000011;
    localparam logic [5:0] fnSllv = 6'b000100;
    localparam logic [5:0] fnSrlv = 6'b000110;
    localparam logic [5:0] fnSrav = 6'b000111;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    // rt field selects the regimm branch
    localparam regAddrT rtBltz = 5'b00000;
    localparam regAddrT rtBgez = 5'b00001;

endpackage

/* hw/decode.sv */
`timescale 1ns/10ps

module decode (
    input  mipsPkg::wordT    instruction,
    input  logic             waitrequest,

    output mipsPkg::regAddrT rs,
    output mipsPkg::regAddrT rt,
    output mipsPkg::regAddrT rd,
    output mipsPkg::immT     immediate,
    output logic [25:0]      address,
    output mipsPkg::shamtT   shamt,

    output mipsPkg::aluOpT   aluOp,
    output logic             useImm,
    output logic             zeroExtImm,
    output logic             shiftVar,
    output logic             regWrite,
    output logic             writeRt,
    output logic             link,
    output logic             memRead,
    output logic             memWrite,
    output mipsPkg::branchT  branch,
    output logic             jump,
    output logic             jumpReg,
    output logic             stall
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode    = instruction[31:26];
    assign funct     = instruction[5:0];
    assign rs        = instruction[25:21];  // Base or first source
    assign rt        = instruction[20:16];  // Target or second source
    assign rd        = instruction[15:11];  // R-type destination
    assign shamt     = instruction[10:6];
    assign immediate = instruction[15:0];
    assign address   = instruction[25:0];   // J-type word index

    always_comb begin
        aluOp      = mipsPkg::aluAdd;
        useImm     = 1'b0;
        zeroExtImm = 1'b0;
        shiftVar   = 1'b0;
        regWrite   = 1'b0;
        writeRt    = 1'b0;
        link       = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        branch     = mipsPkg::brNone;
        jump       = 1'b0;
        jumpReg    = 1'b0;
        case (opcode)
            mipsPkg::opSpecial: begin
                regWrite = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnSll:  aluOp = mipsPkg::aluSll;
                    mipsPkg::fnSrl:  aluOp = mipsPkg::aluSrl;
                    mipsPkg::fnSra:  aluOp = mipsPkg::aluSra;
                    mipsPkg::fnSllv: begin
                        aluOp    = mipsPkg::aluSll;
                        shiftVar = 1'b1;
                    end
                    mipsPkg::fnSrlv: begin
                        aluOp    = mipsPkg::aluSrl;
                        shiftVar = 1'b1;
                    end
                    mipsPkg::fnSrav: begin
                        aluOp    = mipsPkg::aluSra;
                        shiftVar = 1'b1;
                    end
                    mipsPkg::fnJr: begin
                        regWrite = 1'b0;
                        jumpReg  = 1'b1;
                    end
                    default: regWrite = 1'b0;  // Unsupported funct is a no-op
                endcase
            end
            mipsPkg::opRegimm: begin
                if (rt == mipsPkg::rtBltz) branch = mipsPkg::brLtz;
                else if (rt == mipsPkg::rtBgez) branch = mipsPkg::brGez;
            end
            mipsPkg::opBeq:  branch = mipsPkg::brEq;
            mipsPkg::opBne:  branch = mipsPkg::brNe;
            mipsPkg::opBlez: if (rt == '0) branch = mipsPkg::brLez;
            mipsPkg::opBgtz: if (rt == '0) branch = mipsPkg::brGtz;
            mipsPkg::opJ:    jump = 1'b1;
            mipsPkg::opJal: begin
                jump     = 1'b1;
                link     = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu, mipsPkg::opAndi,
            mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui, mipsPkg::opLw: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                writeRt  = 1'b1;
                case (opcode)
                    mipsPkg::opSlti:  aluOp = mipsPkg::aluSlt;
                    mipsPkg::opSltiu: aluOp = mipsPkg::aluSltu;
                    mipsPkg::opAndi:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::opOri:   aluOp = mipsPkg::aluOr;
                    mipsPkg::opXori:  aluOp = mipsPkg::aluXor;
                    mipsPkg::opLui:   aluOp = mipsPkg::aluLui;
                    mipsPkg::opLw:    memRead = 1'b1;
                    default:          aluOp = mipsPkg::aluAdd;
                endcase
                zeroExtImm = (opcode == mipsPkg::opAndi) || (opcode == mipsPkg::opOri)
                          || (opcode == mipsPkg::opXori) || (opcode == mipsPkg::opLui);
            end
            mipsPkg::opSw: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            default: ;  // Anything else retires as a no-op
        endcase
    end

    assign stall = waitrequest && (memRead || memWrite);  // Only lw and sw wait

endmodule

/* hw/regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::regAddrT readAddrA,
    input  mipsPkg::regAddrT readAddrB,
    input  mipsPkg::regAddrT writeAddr,
    input  logic             writeEnable,
    input  mipsPkg::wordT    writeValue,
    output mipsPkg::wordT    readValueA,
    output mipsPkg::wordT    readValueB
);

    mipsPkg::wordT regs [1:31];  // Register 0 has no storage

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeValue;
        end
    end

    assign readValueA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readValueB = (readAddrB == '0) ? '0 : regs[readAddrB];

    // A captured result is always fully known
    assert property (@(posedge clk) disable iff (!arstN)
        (writeEnable && (writeAddr != '0)) |-> !$isunknown(writeValue))
        else $error("regFile: unknown value written to register %0d", writeAddr);

endmodule

/* hw/alu.sv */
`timescale 1ns/10ps

module alu (
    input  mipsPkg::aluOpT aluOp,
    input  mipsPkg::wordT  operandA,
    input  mipsPkg::wordT  operandB,
    input  mipsPkg::shamtT shiftAmount,
    output mipsPkg::wordT  result
);

    mipsPkg::wordT sum;
    mipsPkg::wordT difference;
    logic          lessSigned;
    logic          lessUnsigned;

    assign sum          = operandA + operandB;
    assign difference   = operandA - operandB;
    assign lessSigned   = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;

    always_comb begin
        case (aluOp)
            mipsPkg::aluAdd: begin
                result = sum;  // Also the lw and sw address
            end
            mipsPkg::aluSub: begin
                result = difference;
            end
            mipsPkg::aluAnd: begin
                result = operandA & operandB;
            end
            mipsPkg::aluOr: begin
                result = operandA | operandB;
            end
            mipsPkg::aluXor: begin
                result = operandA ^ operandB;
            end
            mipsPkg::aluSlt: begin
                result = {31'b0, lessSigned};
            end
            mipsPkg::aluSltu: begin
                result = {31'b0, lessUnsigned};
            end
            mipsPkg::aluSll: begin
                result = operandB << shiftAmount;
            end
            mipsPkg::aluSrl: begin
                result = operandB >> shiftAmount;
            end
            mipsPkg::aluSra: begin
                result = $unsigned($signed(operandB) >>> shiftAmount);  // Sign fills from the left
            end
            mipsPkg::aluLui: begin
                result = {operandB[15:0], 16'h0000};
            end
            default: begin
                result = sum;
            end
        endcase
    end

endmodule

/* hw/nextPc.sv */
`timescale 1ns/10ps

module nextPc #(
    parameter mipsPkg::wordT resetVector = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            stall,
    input  mipsPkg::branchT branch,
    input  logic            jump,
    input  logic            jumpReg,
    input  mipsPkg::immT    immediate,
    input  logic [25:0]     address,
    input  mipsPkg::wordT   regValueA,
    input  mipsPkg::wordT   regValueB,
    output mipsPkg::wordT   pc,
    output mipsPkg::wordT   pcPlus4
);

    mipsPkg::wordT branchTarget;
    mipsPkg::wordT jumpTarget;
    mipsPkg::wordT pcNext;
    logic          taken;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{immediate[15]}}, immediate, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], address, 2'b00};  // Stays in the current region

    always_comb begin
        case (branch)
            mipsPkg::brEq:  taken = (regValueA == regValueB);
            mipsPkg::brNe:  taken = (regValueA != regValueB);
            mipsPkg::brLez: taken = regValueA[31] || (regValueA == '0);
            mipsPkg::brGtz: taken = !regValueA[31] && (regValueA != '0);
            mipsPkg::brLtz: taken = regValueA[31];
            mipsPkg::brGez: taken = !regValueA[31];
            default:        taken = 1'b0;
        endcase
    end

    assign pcNext = jumpReg ? regValueA
                  : jump    ? jumpTarget
                  : taken   ? branchTarget
                  : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) pc <= resetVector;
        else if (!stall) pc <= pcNext;  // Hold while the data port waits
    end

    // Misaligned jr targets or reset vectors would break instruction fetch
    assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("nextPc: fetch address not word aligned");

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore #(
    parameter mipsPkg::wordT resetVector = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          arstN,
    output mipsPkg::wordT instrAddress,
    input  mipsPkg::wordT instruction,
    output mipsPkg::wordT dataAddress,
    output mipsPkg::wordT writeData,
    output logic          read,
    output logic          write,
    input  mipsPkg::wordT readData,
    input  logic          waitrequest
);

    mipsPkg::regAddrT rs;
    mipsPkg::regAddrT rt;
    mipsPkg::regAddrT rd;
    mipsPkg::immT     immediate;
    logic [25:0]      address;
    mipsPkg::shamtT   shamt;
    mipsPkg::aluOpT   aluOp;
    logic             useImm;
    logic             zeroExtImm;
    logic             shiftVar;
    logic             regWrite;
    logic             writeRt;
    logic             link;
    logic             memRead;
    logic             memWrite;
    mipsPkg::branchT  branch;
    logic             jump;
    logic             jumpReg;
    logic             stall;

    mipsPkg::wordT    readValueA;
    mipsPkg::wordT    readValueB;
    mipsPkg::wordT    extImm;
    mipsPkg::wordT    operandB;
    mipsPkg::shamtT   shiftAmount;
    mipsPkg::wordT    aluResult;
    mipsPkg::wordT    pcPlus4;
    mipsPkg::regAddrT destReg;
    mipsPkg::wordT    writeValue;

    decode decode0 (
        .instruction(instruction), .waitrequest(waitrequest),
        .rs(rs), .rt(rt), .rd(rd), .immediate(immediate), .address(address), .shamt(shamt),
        .aluOp(aluOp), .useImm(useImm), .zeroExtImm(zeroExtImm), .shiftVar(shiftVar),
        .regWrite(regWrite), .writeRt(writeRt), .link(link),
        .memRead(memRead), .memWrite(memWrite),
        .branch(branch), .jump(jump), .jumpReg(jumpReg), .stall(stall)
    );

    regFile regFile0 (
        .clk(clk), .arstN(arstN),
        .readAddrA(rs), .readAddrB(rt), .writeAddr(destReg),
        .writeEnable(regWrite && !stall), .writeValue(writeValue),
        .readValueA(readValueA), .readValueB(readValueB)
    );

    assign extImm      = zeroExtImm ? {16'h0000, immediate} : {{16{immediate[15]}}, immediate};
    assign operandB    = useImm ? extImm : readValueB;
    assign shiftAmount = shiftVar ? readValueA[4:0] : shamt;  // Variable shifts take rs

    alu alu0 (
        .aluOp(aluOp), .operandA(readValueA), .operandB(operandB),
        .shiftAmount(shiftAmount), .result(aluResult)
    );

    nextPc #(.resetVector(resetVector)) nextPc0 (
        .clk(clk), .arstN(arstN), .stall(stall),
        .branch(branch), .jump(jump), .jumpReg(jumpReg),
        .immediate(immediate), .address(address),
        .regValueA(readValueA), .regValueB(readValueB),
        .pc(instrAddress), .pcPlus4(pcPlus4)
    );

    // jal links into register 31
    assign destReg    = link ? 5'd31 : (writeRt ? rt : rd);
    assign writeValue = link ? pcPlus4 : (memRead ? readData : aluResult);

    assign dataAddress = aluResult;
    assign writeData   = readValueB;
    assign read        = memRead;
    assign write       = memWrite;

endmodule

/* sim/clockGen.sv */
`timescale 1ns/10ps

module clockGen #(
    parameter int period      = 40,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk   = 1'b0;
        arstN = 1'b0;
        #(resetCycles * period - period / 4);  // Release between edges
        arstN = 1'b1;
    end

    always #(period / 2) clk = ~clk;

endmodule

/* sim/mipsCoreTb.sv */
`timescale 1ns/10ps

module mipsCoreTb;

    localparam int period = 40;
    localparam mipsPkg::wordT startPc = 32'h0000_0000;

    logic clk;
    logic arstN;
    mipsPkg::wordT instrAddress, instruction, dataAddress, writeData, readData;
    logic read, write, waitrequest;

    mipsPkg::wordT prog [256];
    int            secOf [256];
    mipsPkg::wordT dmem [512];
    mipsPkg::wordT expFetch [$];
    mipsPkg::wordT expStoreAddr [$];
    mipsPkg::wordT expStoreData [$];
    mipsPkg::wordT haltWord;
    mipsPkg::wordT heldPc, heldAddr, heldData;
    logic [31:0]   rngState = 32'h3a66_71b4;
    string         testNames [1:6];
    int            testErr [1:6];
    int pcIdx, storeOff, memCount, limit, cycles, errors, failedTests;
    int fetchIdx, storeIdx, curTest, waitLeft;
    logic holding, done;

    clockGen #(.period(period), .resetCycles(4)) clockGen0 (.clk(clk), .arstN(arstN));

    mipsCore #(.resetVector(startPc)) dut0 (
        .clk(clk), .arstN(arstN), .instrAddress(instrAddress), .instruction(instruction),
        .dataAddress(dataAddress), .writeData(writeData), .read(read), .write(write),
        .readData(readData), .waitrequest(waitrequest)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic mipsPkg::immT randImm();
        mipsPkg::wordT w;
        w = nextRand();
        return w[15:0];
    endfunction

    function automatic mipsPkg::wordT fillWord(input int i);
        mipsPkg::wordT a;
        a = i * 4;
        return {~a[15:0], a[15:0]};  // Every word differs
    endfunction

    function automatic mipsPkg::wordT rType(input logic [5:0] fn, input mipsPkg::regAddrT s,
            input mipsPkg::regAddrT t, input mipsPkg::regAddrT d, input mipsPkg::shamtT sh);
        return {6'b000000, s, t, d, sh, fn};
    endfunction

    function automatic mipsPkg::wordT iType(input logic [5:0] op, input mipsPkg::regAddrT s,
            input mipsPkg::regAddrT t, input mipsPkg::immT imm);
        return {op, s, t, imm};
    endfunction

    function automatic void emit(input mipsPkg::wordT w, input int test);
        prog[pcIdx]  = w;
        secOf[pcIdx] = test;
        pcIdx++;
    endfunction

    function automatic void loadConst(input mipsPkg::regAddrT r, input mipsPkg::wordT v,
            input int test);
        emit(iType(mipsPkg::opLui, 5'd0, r, v[31:16]), test);
        emit(iType(mipsPkg::opOri, r, r, v[15:0]), test);
    endfunction

    function automatic void storeReg(input mipsPkg::regAddrT r, input int test);
        mipsPkg::wordT off;
        off = storeOff;
        emit(iType(mipsPkg::opSw, 5'd0, r, off[15:0]), test);
        storeOff += 4;
    endfunction

    function automatic void execStore(input mipsPkg::wordT w, input mipsPkg::regAddrT r,
            input int test);
        emit(w, test);
        storeReg(r, test);
    endfunction

    function automatic void buildProgram();
        mipsPkg::wordT tgt;
        mipsPkg::wordT inc;
        mipsPkg::regAddrT r;
        inc = iType(mipsPkg::opAddiu, 5'd6, 5'd6, 16'd1);
        loadConst(5'd1, nextRand(), 1);
        loadConst(5'd2, nextRand(), 1);
        execStore(iType(mipsPkg::opAddiu, 5'd1, 5'd3, randImm()), 5'd3, 1);
        execStore(rType(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 1);
        execStore(rType(mipsPkg::fnSubu, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 1);
        execStore(rType(mipsPkg::fnAnd, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 1);
        execStore(rType(mipsPkg::fnOr, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 1);
        execStore(rType(mipsPkg::fnXor, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 1);
        execStore(rType(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 1);
        execStore(rType(mipsPkg::fnSltu, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 1);
        execStore(iType(mipsPkg::opAndi, 5'd1, 5'd3, randImm()), 5'd3, 1);
        execStore(iType(mipsPkg::opOri, 5'd1, 5'd3, randImm()), 5'd3, 1);
        execStore(iType(mipsPkg::opXori, 5'd1, 5'd3, randImm()), 5'd3, 1);
        execStore(iType(mipsPkg::opLui, 5'd0, 5'd3, randImm()), 5'd3, 1);
        execStore(iType(mipsPkg::opSlti, 5'd1, 5'd3, randImm()), 5'd3, 1);
        execStore(iType(mipsPkg::opSltiu, 5'd1, 5'd3, randImm()), 5'd3, 1);
        loadConst(5'd4, nextRand(), 2);
        execStore(rType(mipsPkg::fnSll, 5'd0, 5'd1, 5'd3, 5'd7), 5'd3, 2);
        execStore(rType(mipsPkg::fnSrl, 5'd0, 5'd1, 5'd3, 5'd31), 5'd3, 2);
        execStore(rType(mipsPkg::fnSra, 5'd0, 5'd2, 5'd3, 5'd13), 5'd3, 2);
        execStore(rType(mipsPkg::fnSllv, 5'd4, 5'd2, 5'd3, 5'd0), 5'd3, 2);
        execStore(rType(mipsPkg::fnSrlv, 5'd4, 5'd2, 5'd3, 5'd0), 5'd3, 2);
        execStore(rType(mipsPkg::fnSrav, 5'd4, 5'd2, 5'd3, 5'd0), 5'd3, 2);
        execStore(iType(mipsPkg::opLw, 5'd0, 5'd5, 16'h0400), 5'd5, 3);
        execStore(iType(mipsPkg::opLw, 5'd0, 5'd5, 16'h0208), 5'd5, 3);
        loadConst(5'd7, nextRand() | 32'h8000_0000, 4);  // Negative operand
        loadConst(5'd8, (nextRand() & 32'h7fff_ffff) | 32'd1, 4);
        for (int k = 0; k < 2; k++) begin
            r = (k == 0) ? 5'd7 : 5'd8;
            emit(iType(mipsPkg::opBeq, r, r, 16'd1), 4);
            emit(inc, 4);
            emit(iType(mipsPkg::opBeq, r, 5'd2, 16'd1), 4);
            emit(inc, 4);
            emit(iType(mipsPkg::opBne, r, r, 16'd1), 4);
            emit(inc, 4);
            emit(iType(mipsPkg::opBne, r, 5'd2, 16'd1), 4);
            emit(inc, 4);
            emit(iType(mipsPkg::opBlez, r, 5'd0, 16'd1), 4);
            emit(inc, 4);
            emit(iType(mipsPkg::opBgtz, r, 5'd0, 16'd1), 4);
            emit(inc, 4);
            emit(iType(mipsPkg::opRegimm, r, mipsPkg::rtBltz, 16'd1), 4);
            emit(inc, 4);
            emit(iType(mipsPkg::opRegimm, r, mipsPkg::rtBgez, 16'd1), 4);
            emit(inc, 4);
        end
        storeReg(5'd6, 4);
        tgt = startPc + (pcIdx + 2) * 4;
        emit({mipsPkg::opJal, tgt[27:2]}, 5);
        emit(inc, 5);
        storeReg(5'd31, 5);
        tgt = startPc + (pcIdx + 2) * 4;
        emit({mipsPkg::opJ, tgt[27:2]}, 5);
        emit(inc, 5);
        tgt = startPc + (pcIdx + 4) * 4;
        loadConst(5'd9, tgt, 5);
        emit(rType(mipsPkg::fnJr, 5'd9, 5'd0, 5'd0, 5'd0), 5);
        emit(inc, 5);
        storeReg(5'd6, 5);
        emit(rType(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd0, 5'd0), 6);
        execStore(iType(mipsPkg::opAddiu, 5'd1, 5'd0, 16'h1234), 5'd0, 6);
        haltWord = iType(mipsPkg::opBeq, 5'd0, 5'd0, 16'hffff);  // Spins on itself
        emit(haltWord, 6);
    endfunction

    // ISA model of the program that yields the fetch order and the stores
    function automatic void runModel();
        mipsPkg::wordT r [32];
        mipsPkg::wordT mdm [512];
        mipsPkg::wordT pc, ins, next, rsv, rtv, simm, zimm, ea, brTgt;
        logic [5:0] op;
        logic [5:0] fn;
        mipsPkg::regAddrT rsA, rtA, rdA;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 512; i++) mdm[i] = fillWord(i);
        pc = startPc;
        for (int step = 0; step < 1000; step++) begin
            ins = prog[pc[9:2]];
            expFetch.push_back(pc);
            if (ins == haltWord) break;
            op = ins[31:26];
            fn = ins[5:0];
            rsA = ins[25:21];
            rtA = ins[20:16];
            rdA = ins[15:11];
            rsv = r[rsA];
            rtv = r[rtA];
            simm = {{16{ins[15]}}, ins[15:0]};
            zimm = {16'h0000, ins[15:0]};
            next = pc + 4;
            brTgt = next + (simm << 2);
            ea = rsv + simm;
            case (op)
                mipsPkg::opSpecial: case (fn)
                    mipsPkg::fnSll:  r[rdA] = rtv << ins[10:6];
                    mipsPkg::fnSrl:  r[rdA] = rtv >> ins[10:6];
                    mipsPkg::fnSra:  r[rdA] = $signed(rtv) >>> ins[10:6];
                    mipsPkg::fnSllv: r[rdA] = rtv << rsv[4:0];
                    mipsPkg::fnSrlv: r[rdA] = rtv >> rsv[4:0];
                    mipsPkg::fnSrav: r[rdA] = $signed(rtv) >>> rsv[4:0];
                    mipsPkg::fnJr:   next = rsv;
                    mipsPkg::fnAddu: r[rdA] = rsv + rtv;
                    mipsPkg::fnSubu: r[rdA] = rsv - rtv;
                    mipsPkg::fnAnd:  r[rdA] = rsv & rtv;
                    mipsPkg::fnOr:   r[rdA] = rsv | rtv;
                    mipsPkg::fnXor:  r[rdA] = rsv ^ rtv;
                    mipsPkg::fnSlt:  r[rdA] = ($signed(rsv) < $signed(rtv)) ? 1 : 0;
                    mipsPkg::fnSltu: r[rdA] = (rsv < rtv) ? 1 : 0;
                    default: ;
                endcase
                mipsPkg::opRegimm: begin
                    if (rtA == 5'd0 && $signed(rsv) < 0) next = brTgt;
                    if (rtA == 5'd1 && $signed(rsv) >= 0) next = brTgt;
                end
                mipsPkg::opJ:    next = {next[31:28], ins[25:0], 2'b00};
                mipsPkg::opJal: begin
                    r[31] = pc + 4;
                    next  = {next[31:28], ins[25:0], 2'b00};
                end
                mipsPkg::opBeq:   if (rsv == rtv) next = brTgt;
                mipsPkg::opBne:   if (rsv != rtv) next = brTgt;
                mipsPkg::opBlez:  if ($signed(rsv) <= 0) next = brTgt;
                mipsPkg::opBgtz:  if ($signed(rsv) > 0) next = brTgt;
                mipsPkg::opAddiu: r[rtA] = rsv + simm;
                mipsPkg::opSlti:  r[rtA] = ($signed(rsv) < $signed(simm)) ? 1 : 0;
                mipsPkg::opSltiu: r[rtA] = (rsv < simm) ? 1 : 0;
                mipsPkg::opAndi:  r[rtA] = rsv & zimm;
                mipsPkg::opOri:   r[rtA] = rsv | zimm;
                mipsPkg::opXori:  r[rtA] = rsv ^ zimm;
                mipsPkg::opLui:   r[rtA] = {ins[15:0], 16'h0000};
                mipsPkg::opLw: begin
                    r[rtA] = mdm[ea[10:2]];
                    memCount++;
                end
                mipsPkg::opSw: begin
                    mdm[ea[10:2]] = rtv;
                    expStoreAddr.push_back(ea);
                    expStoreData.push_back(rtv);
                    memCount++;
                end
                default: ;
            endcase
            r[0] = '0;
            pc = next;
        end
    endfunction

    task automatic fail(input string msg);
        $display("%s", msg);
        errors++;
        testErr[curTest]++;
    endtask

    task automatic checkWord(input string name, input mipsPkg::wordT got,
            input mipsPkg::wordT exp);
        if (got !== exp)
            fail($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkAddress(input string name, input mipsPkg::wordT got,
            input mipsPkg::wordT exp);
        if (got !== exp)
            fail($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic reportTest(input int t);
        if (testErr[t] != 0) failedTests++;
        $display("Test %0d %s: %s (%0d errors)", t, testNames[t],
                 (testErr[t] == 0) ? "ok" : "FAILED", testErr[t]);
    endtask

    initial begin
        instruction = '0;
        readData    = '0;
        waitrequest = 1'b0;
        testNames   = '{"arithmetic and logic", "shifts", "back-pressure", "branches",
                        "jumps", "register 0"};
        for (int i = 0; i < 256; i++) begin
            prog[i]  = '0;
            secOf[i] = 6;
        end
        for (int i = 0; i < 512; i++) dmem[i] = fillWord(i);
        for (int t = 1; t <= 6; t++) testErr[t] = 0;
        pcIdx       = 0;
        storeOff    = 32'h400;
        memCount    = 0;
        cycles      = 0;
        errors      = 0;
        failedTests = 0;
        fetchIdx    = 0;
        storeIdx    = 0;
        curTest     = 1;
        waitLeft    = 0;
        holding     = 1'b0;
        done        = 1'b0;
        buildProgram();
        runModel();
        limit = 4 * expFetch.size() + 16 * memCount;
    end

    // Memory ports with 0 to 3 wait cycles per access
    always @(negedge clk) begin
        mipsPkg::wordT ins;
        ins = prog[instrAddress[9:2]];
        instruction = ins;
        if (ins[31:26] == mipsPkg::opLw || ins[31:26] == mipsPkg::opSw) begin
            if (waitLeft == 0) waitLeft = int'(nextRand() % 4);
            else waitLeft--;
        end else begin
            waitLeft = 0;
        end
        waitrequest = (waitLeft != 0);
        #1;
        readData = dmem[dataAddress[10:2]];
    end

    always @(negedge clk) begin
        logic stallNow;
        logic expRead;
        logic expWrite;
        int sec;
        #(period / 4);
        if (arstN && !done) begin
            expRead  = (instruction[31:26] == mipsPkg::opLw);
            expWrite = (instruction[31:26] == mipsPkg::opSw);
            stallNow = waitrequest && (expRead || expWrite);
            checkLevel("read", read, expRead);
            checkLevel("write", write, expWrite);
            if (holding) begin  // Port must not move while waiting
                checkAddress("instrAddress", instrAddress, heldPc);
                checkAddress("dataAddress", dataAddress, heldAddr);
                checkWord("writeData", writeData, heldData);
            end
            holding  = stallNow;
            heldPc   = instrAddress;
            heldAddr = dataAddress;
            heldData = writeData;
            if (!stallNow) begin
                sec = secOf[instrAddress[9:2]];
                if (sec != curTest) begin
                    reportTest(curTest);
                    curTest = sec;
                end
                checkAddress("instrAddress", instrAddress, expFetch[fetchIdx]);
                if (expWrite) begin
                    if (storeIdx < expStoreAddr.size()) begin
                        checkAddress("dataAddress", dataAddress, expStoreAddr[storeIdx]);
                        checkWord("writeData", writeData, expStoreData[storeIdx]);
                    end else begin
                        fail("The core stored more words than the program holds");
                    end
                    storeIdx++;
                    dmem[dataAddress[10:2]] = writeData;
                end
                fetchIdx++;
                if (fetchIdx == expFetch.size()) begin
                    done = 1'b1;
                    if (storeIdx != expStoreAddr.size())
                        fail("The core made fewer stores than the program holds");
                    reportTest(curTest);
                    $display("Summary: %0d tests, %0d failed, %0d errors",
                             curTest, failedTests, errors);
                    if (errors == 0) $display("test passed");
                    else $display("test failed");
                    $finish;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (arstN && !done) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: the program did not finish within %0d cycles", limit);
                $display("test failed");
                $finish;
            end
        end
    end

endmodule

/* mipsCore.f */
hw/mipsPkg.sv
hw/decode.sv
hw/regFile.sv
hw/alu.sv
hw/nextPc.sv
hw/mipsCore.sv
sim/clockGen.sv
sim/mipsCoreTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsCoreTb
FILELIST  = mipsCore.f
BUILDDIR  = obj_dir
LOG       = sim.log

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
